// File: rcntlr_config.svh
`ifndef RCNTLR_CONFIG_SVH
`define RCNTLR_CONFIG_SVH

`define DATA_W             16 // spi frame width
`define RCNTLR_ADDR_W      3  // register address width
`define RCNTLR_REG_W       8  // register width
`define RCNTLR_NREGS       8  // slots incl. status port
`define RCNTLR_STATUS_ADDR 7  // read-only status slot

`endif

// File: spi_pkg.sv
`include "rcntlr_config.svh"

package spi_pkg;

  typedef logic [`DATA_W-1:0] spi_word_t; // one frame, msb first on the wire

  // frame tracker, set by ss falling edge, cleared by ss rising edge
  typedef enum logic {
    SPI_FRAME_IDLE   = 1'b0,
    SPI_FRAME_ACTIVE = 1'b1
  } spi_frame_e;

endpackage

// File: rcntlr_pkg.sv
`include "rcntlr_config.svh"

package rcntlr_pkg;

  typedef enum logic [1:0] {
    OP_NOP    = 2'd0, // clears the response
    OP_WRITE  = 2'd1,
    OP_READ   = 2'd2,
    OP_STATUS = 2'd3  // accepted write count
  } rcntlr_op_e;

  typedef logic [`RCNTLR_ADDR_W-1:0] rcntlr_addr_t;
  typedef logic [`RCNTLR_REG_W-1:0]  rcntlr_data_t;

  typedef enum logic {
    CMD_IDLE = 1'b0, // waiting for a frame
    CMD_EXEC = 1'b1  // one cycle, decode and respond
  } rcntlr_cmd_e;

  // field view of a frame word, same layout for command and response
  typedef struct packed {
    rcntlr_op_e                                       op;
    rcntlr_addr_t                                     addr;
    logic [`DATA_W-2-`RCNTLR_ADDR_W-`RCNTLR_REG_W-1:0] rsvd; // sent as zero
    rcntlr_data_t                                     data;
  } rcntlr_frame_t;

endpackage

// File: spi_fe.sv
`timescale 1ns/1ps
`include "rcntlr_config.svh"

module spi_fe (
  input  logic               clk,
  input  logic               rst,
  input  logic               sclk,        // serial clock from the master
  input  logic               ss,          // slave select, active low
  input  logic               mosi,
  output logic               miso,
  input  spi_pkg::spi_word_t data_in,     // response, read while shifting
  output spi_pkg::spi_word_t data_out,    // received word
  output logic               ss_pos_edge, // frame end, on the trailer pulse
  output logic               ss_neg_edge  // frame start, first falling edge
);
  import spi_pkg::*;

  logic [2:0] sclk_samples;  // sync chain, [2] is oldest
  logic       ss_sample;     // ss as seen at the last sclk fall
  logic       sclk_pos_edge;
  logic       sclk_neg_edge;
  spi_word_t  rx_reg;        // mosi shift register
  spi_word_t  tx_mask;       // one-hot bit select for miso

  assign sclk_pos_edge = ~sclk_samples[2] & sclk_samples[1];
  assign sclk_neg_edge = sclk_samples[2] & ~sclk_samples[1];

  // ss edges only seen on an sclk fall, hence the trailer pulse
  assign ss_pos_edge = ~ss_sample & ss & sclk_neg_edge;
  assign ss_neg_edge = ss_sample & ~ss & sclk_neg_edge;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sclk_samples <= '0;
      ss_sample    <= 1'b1; // deselected
    end else begin
      sclk_samples <= {sclk_samples[1:0], sclk};
      if (sclk_neg_edge) begin
        ss_sample <= ss;
      end
    end
  end

  // mosi sampled on the falling edge, msb arrives first
  always_ff @(posedge clk) begin
    if (~ss & sclk_neg_edge) begin
      rx_reg <= {rx_reg[`DATA_W-2:0], mosi};
    end
  end

  assign data_out = rx_reg;

  // mask parks at bit 0, first rise moves it to bit 15
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_mask <= spi_word_t'(1);
    end else if (ss) begin
      tx_mask <= spi_word_t'(1); // rearm between frames
    end else if (sclk_pos_edge) begin
      tx_mask <= {tx_mask[0], tx_mask[`DATA_W-1:1]}; // rotate right
    end
  end

  assign miso = |(tx_mask & data_in); // launched after each rise

endmodule

// File: rcntlr_cmd.sv
`timescale 1ns/1ps
`include "rcntlr_config.svh"

module rcntlr_cmd (
  input  logic                    clk,
  input  logic                    rst,
  input  spi_pkg::spi_word_t      rx_word,     // word from the front end
  input  logic                    frame_start, // ss falling edge pulse
  input  logic                    frame_end,   // ss rising edge pulse
  output spi_pkg::spi_word_t      tx_word,     // response for the next frame
  output logic                    wr_en,       // one-cycle write strobe
  output rcntlr_pkg::rcntlr_addr_t wr_addr,
  output rcntlr_pkg::rcntlr_data_t wr_data,
  output rcntlr_pkg::rcntlr_addr_t rd_addr,
  input  rcntlr_pkg::rcntlr_data_t rd_data     // combinational from regfile
);
  import spi_pkg::*;
  import rcntlr_pkg::*;

  spi_frame_e    frame_st;  // frame tracker
  rcntlr_cmd_e   state;
  rcntlr_frame_t cmd_q;     // latched command word
  rcntlr_frame_t resp_q;    // response register
  rcntlr_data_t  wr_cnt;    // accepted writes, wraps at 256
  logic          end_valid; // frame_end with a started frame
  logic          is_write;
  logic          wr_ok;     // write to a writable slot

  assign end_valid = frame_end & (frame_st == SPI_FRAME_ACTIVE);
  assign is_write  = (state == CMD_EXEC) & (cmd_q.op == OP_WRITE);
  assign wr_ok     = is_write & (cmd_q.addr != rcntlr_addr_t'(`RCNTLR_STATUS_ADDR));

  // stray frame_end after reset is dropped here
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      frame_st <= SPI_FRAME_IDLE;
    end else if (frame_start) begin
      frame_st <= SPI_FRAME_ACTIVE;
    end else if (frame_end) begin
      frame_st <= SPI_FRAME_IDLE;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= CMD_IDLE;
    end else begin
      case (state)
        CMD_IDLE: if (end_valid) state <= CMD_EXEC;
        CMD_EXEC: state <= CMD_IDLE; // single exec cycle
        default:  state <= CMD_IDLE;
      endcase
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    if (end_valid) begin
      cmd_q <= rcntlr_frame_t'(rx_word);
    end
  end

  assign wr_en   = is_write; // regfile drops the status slot itself
  assign wr_addr = cmd_q.addr;
  assign wr_data = cmd_q.data;
  assign rd_addr = cmd_q.addr;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_cnt <= '0;
    end else if (wr_ok) begin
      wr_cnt <= wr_cnt + 1'b1;
    end
  end

  // response loaded in the exec cycle, shifted out next frame
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      resp_q <= '0;
    end else if (state == CMD_EXEC) begin
      resp_q.op   <= cmd_q.op;   // echo
      resp_q.addr <= cmd_q.addr;
      resp_q.rsvd <= '0;
      case (cmd_q.op)
        OP_NOP:    resp_q <= '0;      // whole word cleared
        OP_WRITE:  resp_q.data <= '0; // header echo only
        OP_READ:   resp_q.data <= rd_data;
        OP_STATUS: resp_q.data <= wr_cnt; // count before any write of this cycle
        default:   resp_q <= '0;
      endcase
    end
  end

  assign tx_word = spi_word_t'(resp_q);

endmodule

// File: rcntlr_regfile.sv
`timescale 1ns/1ps
`include "rcntlr_config.svh"

module rcntlr_regfile (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      wr_en,
  input  rcntlr_pkg::rcntlr_addr_t                  wr_addr,
  input  rcntlr_pkg::rcntlr_data_t                  wr_data,
  input  rcntlr_pkg::rcntlr_addr_t                  rd_addr,
  input  rcntlr_pkg::rcntlr_data_t                  status_in, // read-only port
  output rcntlr_pkg::rcntlr_data_t                  rd_data,
  output logic [`RCNTLR_NREGS*`RCNTLR_REG_W-1:0]    regs_out   // slot i at [8i+7:8i]
);
  import rcntlr_pkg::*;

  localparam int NWR = `RCNTLR_NREGS - 1; // writable slots

  rcntlr_data_t regs [NWR];
  logic         wr_hit;   // write to a stored slot
  logic         rd_stat;  // read of the status slot

  assign wr_hit  = wr_en & (wr_addr != rcntlr_addr_t'(`RCNTLR_STATUS_ADDR));
  assign rd_stat = (rd_addr == rcntlr_addr_t'(`RCNTLR_STATUS_ADDR));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NWR; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_hit) begin
      regs[wr_addr] <= wr_data; // status address never reaches here
    end
  end

  // read mux, status slot comes from the pin
  always_comb begin
    rd_data = status_in;
    if (!rd_stat) begin
      rd_data = regs[rd_addr];
    end
  end

  // flat view, status slot reads zero
  always_comb begin
    regs_out = '0;
    for (int i = 0; i < NWR; i++) begin
      regs_out[i*`RCNTLR_REG_W +: `RCNTLR_REG_W] = regs[i];
    end
  end

endmodule

// File: rcntlr_top.sv
`timescale 1ns/1ps
`include "rcntlr_config.svh"

module rcntlr_top (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   sclk,      // spi pins
  input  logic                                   ss,
  input  logic                                   mosi,
  output logic                                   miso,
  input  rcntlr_pkg::rcntlr_data_t               status_in, // shows up at address 7
  output logic [`RCNTLR_NREGS*`RCNTLR_REG_W-1:0] regs_out
);
  import spi_pkg::*;
  import rcntlr_pkg::*;

  spi_word_t    rx_word;     // fe to decoder
  spi_word_t    tx_word;     // decoder to fe
  logic         frame_start;
  logic         frame_end;
  logic         wr_en;
  rcntlr_addr_t wr_addr;
  rcntlr_data_t wr_data;
  rcntlr_addr_t rd_addr;
  rcntlr_data_t rd_data;

  spi_fe u_spi_fe (
    .clk         (clk),
    .rst         (rst),
    .sclk        (sclk),
    .ss          (ss),
    .mosi        (mosi),
    .miso        (miso),
    .data_in     (tx_word),
    .data_out    (rx_word),
    .ss_pos_edge (frame_end),
    .ss_neg_edge (frame_start)
  );

  rcntlr_cmd u_cmd (
    .clk         (clk),
    .rst         (rst),
    .rx_word     (rx_word),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .tx_word     (tx_word),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data)
  );

  rcntlr_regfile u_regfile (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr   (rd_addr),
    .status_in (status_in),
    .rd_data   (rd_data),
    .regs_out  (regs_out)
  );

endmodule

// File: tb_rcntlr.sv
`timescale 1ns/1ps
`include "rcntlr_config.svh"

module tb_rcntlr;
  import rcntlr_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int HALF       = 6;  // clk cycles per sclk level
  localparam int N_RAND     = 40; // back-to-back random frames
  localparam int N_FRAMES   = 1 + 7 + 8 + 3 + 3 + N_RAND + 1;
  localparam int FRAME_NS   = 40 * HALF * CLK_PERIOD; // 40 sclk half periods
  localparam int TIMEOUT_NS = N_FRAMES * FRAME_NS + 100 * CLK_PERIOD;
  localparam int REGS_W     = `RCNTLR_NREGS * `RCNTLR_REG_W;

  logic               clk;
  logic               rst;
  logic               sclk;
  logic               ss;
  logic               mosi;
  logic               miso;
  rcntlr_data_t       status_in;
  logic [REGS_W-1:0]  regs_out;

  logic [7:0]  model_regs [`RCNTLR_NREGS]; // reference copy, slot 7 unused
  logic [7:0]  model_cnt;                  // accepted writes mod 256
  logic [15:0] exp_resp;                   // due in the next frame
  string       test_name;
  int          n_tests;
  int          n_checks;
  int          n_errors;
  int          test_chk0;
  int          test_err0;

  rcntlr_top DUT (
    .clk       (clk),
    .rst       (rst),
    .sclk      (sclk),
    .ss        (ss),
    .mosi      (mosi),
    .miso      (miso),
    .status_in (status_in),
    .regs_out  (regs_out)
  );

  always #4 clk = ~clk; // 8 ns period

  // a register may only move two cycles after the trailer edge is seen
  assert property (@(posedge clk) disable iff (rst)
    $changed(regs_out) |-> $past(DUT.frame_end, 2))
  else begin
    n_errors++;
    $display("regs_out changed at %0t without a frame end two cycles before", $time);
  end

  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #1; // drive point, 1 ns after the edge
  endtask

  function automatic logic [15:0] make_word(input logic [1:0] op, input logic [2:0] addr,
                                            input logic [7:0] data);
    return {op, addr, 3'b000, data}; // reserved bits zero
  endfunction

  function automatic logic [REGS_W-1:0] expected_regs();
    logic [REGS_W-1:0] flat;
    flat = '0;
    for (int i = 0; i < `RCNTLR_NREGS; i++) begin
      if (i != `RCNTLR_STATUS_ADDR) begin
        flat[i*`RCNTLR_REG_W +: `RCNTLR_REG_W] = model_regs[i];
      end
    end
    return flat;
  endfunction

  // one frame plus trailer, miso collected at each falling edge
  task automatic spi_xfer(input logic [15:0] tx, output logic [15:0] rx);
    ss = 1'b0;
    step(HALF);
    for (int i = 15; i >= 0; i--) begin
      mosi = tx[i]; // msb first
      sclk = 1'b1;
      step(HALF);
      rx[i] = miso;
      sclk = 1'b0;
      step(HALF);
    end
    ss = 1'b1;
    step(HALF);
    sclk = 1'b1; // trailer pulse, lets the fe see ss rise
    step(HALF);
    sclk = 0;
    step(HALF + 2); // covers detect plus the 2-cycle update
  endtask

  // reference behavior per frame, returns the response for the next one
  task automatic model_update(input logic [15:0] w, output logic [15:0] resp);
    logic [1:0] op;
    logic [2:0] addr;
    logic [7:0] data;
    op   = w[15:14];
    addr = w[13:11];
    data = w[7:0];
    case (op)
      OP_NOP: resp = '0;
      OP_WRITE: begin
        resp = make_word(op, addr, 8'h00); // header echo only
        if (addr != `RCNTLR_STATUS_ADDR) begin
          model_regs[addr] = data;
          model_cnt++;
        end
      end
      OP_READ: begin
        resp = make_word(op, addr, (addr == `RCNTLR_STATUS_ADDR) ? status_in : model_regs[addr]);
      end
      default: resp = make_word(op, addr, model_cnt); // status count
    endcase
  endtask

  task automatic run_frame(input logic [15:0] w);
    logic [15:0] rx;
    logic [15:0] resp;
    spi_xfer(w, rx);
    n_checks++;
    assert (rx == exp_resp)
    else begin
      n_errors++;
      $display("[ERROR] %s: miso expected %h, actual %h", test_name, exp_resp, rx);
    end
    model_update(w, resp);
    exp_resp = resp;
    n_checks++;
    assert (regs_out == expected_regs())
    else begin
      n_errors++;
      $display("[ERROR] %s: regs_out expected %h, actual %h", test_name, expected_regs(),
               regs_out);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_chk0 = n_checks;
    test_err0 = n_errors;
  endtask

  task automatic end_test();
    n_tests++;
    $display("test %s: %0d checks, %0d errors", test_name, n_checks - test_chk0,
             n_errors - test_err0);
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the run did not complete", TIMEOUT_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    logic [2:0] a;
    clk       = 1'b0;
    rst       = 1'b1;
    sclk      = 1'b0;
    ss        = 1'b1;
    mosi      = 1'b0;
    status_in = '0;
    n_tests   = 0;
    n_checks  = 0;
    n_errors  = 0;
    model_cnt = '0;
    exp_resp  = '0; // reset response
    for (int i = 0; i < `RCNTLR_NREGS; i++) begin
      model_regs[i] = '0;
    end
    void'($urandom(96));
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    step(2);

    begin_test("reset");
    n_checks++;
    assert (regs_out == '0)
    else begin
      n_errors++;
      $display("[ERROR] %s: regs_out expected %h, actual %h", test_name, '0, regs_out);
    end
    run_frame(make_word(OP_NOP, 3'd0, 8'h00)); // first response must be zero
    end_test();

    begin_test("write");
    for (int i = 0; i < 7; i++) begin
      run_frame(make_word(OP_WRITE, 3'(i), 8'($urandom)));
    end
    end_test();

    begin_test("read");
    status_in = 8'($urandom);
    for (int i = 0; i < 8; i++) begin
      run_frame(make_word(OP_READ, 3'(i), 8'h00)); // addr 7 gives status_in
    end
    end_test();

    begin_test("status");
    run_frame(make_word(OP_WRITE, 3'd7, 8'($urandom))); // dropped, not counted
    run_frame(make_word(OP_STATUS, 3'd0, 8'h00));
    run_frame(make_word(OP_NOP, 3'd0, 8'h00)); // collects the count
    end_test();

    begin_test("nop");
    a = 3'($urandom);
    run_frame(make_word(OP_READ, a, 8'h00));
    run_frame(make_word(OP_NOP, 3'd0, 8'h00));
    run_frame(make_word(OP_READ, a, 8'h00)); // nop response zero here
    end_test();

    begin_test("random");
    for (int i = 0; i < N_RAND; i++) begin
      status_in = 8'($urandom); // between frames, stable while decoded
      run_frame(make_word(2'($urandom), 3'($urandom), 8'($urandom)));
    end
    run_frame(make_word(OP_NOP, 3'd0, 8'h00)); // flush last response
    end_test();

    $display("tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
spi_pkg.sv
rcntlr_pkg.sv
spi_fe.sv
rcntlr_cmd.sv
rcntlr_regfile.sv
rcntlr_top.sv
tb_rcntlr.sv

// File: Bender.yml
package:
  name: rcntlr

sources:
  - include_dirs:
      - .
    files:
      - spi_pkg.sv
      - rcntlr_pkg.sv
      - spi_fe.sv
      - rcntlr_cmd.sv
      - rcntlr_regfile.sv
      - rcntlr_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rcntlr.sv
